/* rtl/rvx_pkg.sv */
package rvx_pkg;

    // Plain vector widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;

    // RV32I major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_FENCE  = 7'b0001111,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    // Data cache command, held for one cycle only
    typedef enum logic [1:0] {
        CACHE_CMD_NONE      = 2'd0,
        CACHE_CMD_LOAD      = 2'd1,
        CACHE_CMD_STORE     = 2'd2,
        CACHE_CMD_FLUSH_ALL = 2'd3
    } cache_cmd_t;

    typedef enum logic [1:0] {
        CACHE_RESP_NONE  = 2'd0,
        CACHE_RESP_DONE  = 2'd1,
        CACHE_RESP_ERROR = 2'd2
    } cache_resp_t;

    // Source of the rd write data
    typedef enum logic [2:0] {
        RD_SEL_ALU       = 3'd0,
        RD_SEL_LOAD      = 3'd1,
        RD_SEL_LUI       = 3'd2,
        RD_SEL_AUIPC     = 3'd3,
        RD_SEL_PC_PLUS_4 = 3'd4
    } rd_sel_t;

    // Standard mcause codes for the synchronous exceptions raised here
    typedef enum logic [3:0] {
        EXC_ILLEGAL_INSTR = 4'd2,
        EXC_LOAD_FAULT    = 4'd5,
        EXC_STORE_FAULT   = 4'd7
    } exc_cause_t;

    typedef enum logic {
        EXEC_IDLE      = 1'b0,
        EXEC_WAIT_RESP = 1'b1
    } exec_state_t;

    // Cycles after reset before the cache is trusted
    localparam int unsigned RESET_WAIT = 8;

endpackage

/* rtl/rvx_decode.sv */
module rvx_decode import rvx_pkg::*; (
    input  word_t    instr,
    output opcode_t  opcode,
    output funct3_t  funct3,
    output logic     funct7_alt,
    output reg_idx_t rs1_addr,
    output reg_idx_t rs2_addr,
    output reg_idx_t rd_addr,
    output word_t    imm_i,
    output word_t    imm_s,
    output word_t    imm_b,
    output word_t    imm_u,
    output word_t    imm_j,
    output logic     illegal
);

    logic [6:0] funct7;
    logic       sign;

    assign opcode     = opcode_t'(instr[6:0]);
    assign rd_addr    = instr[11:7];
    assign funct3     = instr[14:12];
    assign rs1_addr   = instr[19:15];
    assign rs2_addr   = instr[24:20];
    assign funct7     = instr[31:25];
    assign funct7_alt = instr[30];
    assign sign       = instr[31];

    // Immediates, all sign extended from bit 31
    assign imm_i = {{20{sign}}, instr[31:20]};
    assign imm_s = {{20{sign}}, instr[31:25], instr[11:7]};
    assign imm_b = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'h000};
    assign imm_j = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        illegal = 1'b0;
        case (opcode)
            OPC_OP: begin
                // Alternate funct7 only exists for SUB and SRA
                if (funct7 == 7'h20) begin
                    illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                end else begin
                    illegal = (funct7 != 7'h00);
                end
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b001) begin
                    illegal = (funct7 != 7'h00);
                end else if (funct3 == 3'b101) begin
                    illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
                end
            end
            OPC_JALR: begin
                illegal = (funct3 != 3'b000);
            end
            OPC_STORE: begin
                illegal = (funct3 > 3'd2);
            end
            OPC_LOAD: begin
                illegal = (funct3 == 3'd3) || (funct3 == 3'd6) || (funct3 == 3'd7);
            end
            OPC_BRANCH: begin
                illegal = (funct3 == 3'd2) || (funct3 == 3'd3);
            end
            OPC_FENCE: begin
                // fm field must be zero
                illegal = (instr[31:28] != 4'b0000);
            end
            OPC_LUI, OPC_AUIPC, OPC_JAL: begin
                illegal = 1'b0;
            end
            // SYSTEM is not supported at all
            OPC_SYSTEM: begin
                illegal = 1'b1;
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

/* rtl/rvx_alu.sv */
module rvx_alu import rvx_pkg::*; (
    input  opcode_t opcode,
    input  funct3_t funct3,
    input  logic    funct7_alt,
    input  word_t   op_a,
    input  word_t   op_b,
    output word_t   result,
    output logic    branch_taken
);

    logic       sub_en;
    logic [4:0] shamt;
    logic       eq;
    logic       lt_signed;
    logic       lt_unsigned;

    // OP_IMM has no SUB, bit 30 is part of the immediate there
    assign sub_en      = (opcode == OPC_OP) && funct7_alt;
    assign shamt       = op_b[4:0];
    assign eq          = (op_a == op_b);
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    always_comb begin
        case (funct3)
            3'b000: result = sub_en ? (op_a - op_b) : (op_a + op_b);
            3'b001: result = op_a << shamt;
            3'b010: result = {31'b0, lt_signed};
            3'b011: result = {31'b0, lt_unsigned};
            3'b100: result = op_a ^ op_b;
            3'b101: begin
                if (funct7_alt) begin
                    result = word_t'($signed(op_a) >>> shamt);
                end else begin
                    result = op_a >> shamt;
                end
            end
            3'b110: result = op_a | op_b;
            default: result = op_a & op_b;
        endcase
    end

    // Branch condition, only meaningful for BRANCH
    always_comb begin
        branch_taken = 1'b0;
        if (opcode == OPC_BRANCH) begin
            case (funct3)
                3'b000: branch_taken = eq;
                3'b001: branch_taken = !eq;
                3'b100: branch_taken = lt_signed;
                3'b101: branch_taken = !lt_signed;
                3'b110: branch_taken = lt_unsigned;
                3'b111: branch_taken = !lt_unsigned;
                default: branch_taken = 1'b0;
            endcase
        end
    end

endmodule

/* rtl/rvx_execute_ctrl.sv */
module rvx_execute_ctrl import rvx_pkg::*; #(
    parameter int unsigned RESET_WAIT = rvx_pkg::RESET_WAIT
) (
    input  logic        clk,
    input  logic        rst_n,
    input  opcode_t     opcode,
    input  funct3_t     funct3,
    input  reg_idx_t    rd_addr,
    input  logic        illegal,
    input  addr_t       pc,
    input  word_t       rs1_data,
    input  word_t       rs2_data,
    input  word_t       imm_i,
    input  word_t       imm_s,
    input  word_t       imm_b,
    input  word_t       imm_j,
    input  logic        branch_taken_alu,
    input  cache_resp_t c_response,
    input  logic        c_reset_done,
    output cache_cmd_t  c_cmd,
    output addr_t       c_address,
    output word_t       c_store_data,
    output logic [3:0]  c_store_strb,
    output logic        ready,
    output logic        flush,
    output logic        branch_taken,
    output addr_t       branch_target,
    output logic        exc_start,
    output exc_cause_t  exc_cause,
    output rd_sel_t     rd_sel,
    output logic        rd_write
);

    localparam int CNT_W = $clog2(RESET_WAIT + 2);

    exec_state_t state;
    exec_state_t state_next;
    logic [CNT_W-1:0] wait_cnt;
    logic wait_done;
    logic cache_ready;
    logic is_load, is_store, is_fence, is_mem;
    logic is_jal, is_jalr, is_branch;
    logic resp_seen, resp_error;
    logic writes_rd;
    logic [1:0] byte_offset;
    cache_cmd_t mem_cmd;

    // Illegal encodings never reach the cache
    assign is_load   = (opcode == OPC_LOAD) && !illegal;
    assign is_store  = (opcode == OPC_STORE) && !illegal;
    assign is_fence  = (opcode == OPC_FENCE) && !illegal;
    assign is_mem    = is_load || is_store || is_fence;
    assign is_jal    = (opcode == OPC_JAL) && !illegal;
    assign is_jalr   = (opcode == OPC_JALR) && !illegal;
    assign is_branch = (opcode == OPC_BRANCH) && !illegal;

    assign cache_ready = wait_done && c_reset_done;
    assign resp_error  = (c_response == CACHE_RESP_ERROR);
    assign resp_seen   = (c_response == CACHE_RESP_DONE) || resp_error;

    assign c_address   = (opcode == OPC_STORE) ? (rs1_data + imm_s) : (rs1_data + imm_i);
    assign byte_offset = c_address[1:0];

    // Store data goes to the lanes picked by the low address bits
    assign c_store_data = rs2_data << {byte_offset, 3'b000};
    always_comb begin
        case (funct3[1:0])
            2'b00: c_store_strb = 4'b0001 << byte_offset;
            2'b01: c_store_strb = 4'b0011 << byte_offset;
            default: c_store_strb = 4'b1111;
        endcase
    end

    assign mem_cmd = is_load ? CACHE_CMD_LOAD :
                     is_store ? CACHE_CMD_STORE : CACHE_CMD_FLUSH_ALL;

    always_comb begin
        state_next = state;
        c_cmd = CACHE_CMD_NONE;
        ready = 1'b0;
        if (is_mem) begin
            if (state == EXEC_IDLE) begin
                if (cache_ready) begin
                    c_cmd = mem_cmd;
                    state_next = EXEC_WAIT_RESP;
                end
            end else if (resp_seen) begin
                ready = 1'b1;
                state_next = EXEC_IDLE;
            end
        end else begin
            // Everything else finishes in the cycle it is presented
            ready = cache_ready;
        end
    end

    // Priority is illegal, then load fault, then store fault
    always_comb begin
        exc_start = 1'b0;
        exc_cause = EXC_ILLEGAL_INSTR;
        if (illegal) begin
            exc_start = ready;
        end else if (is_load && resp_error) begin
            exc_start = ready;
            exc_cause = EXC_LOAD_FAULT;
        end else if (is_store && resp_error) begin
            exc_start = ready;
            exc_cause = EXC_STORE_FAULT;
        end
    end

    assign flush        = is_fence && ready;
    assign branch_taken = ready && (is_jal || is_jalr || (is_branch && branch_taken_alu));

    always_comb begin
        case (opcode)
            OPC_JAL:  branch_target = pc + imm_j;
            OPC_JALR: branch_target = (rs1_data + imm_i) & ~32'd1;
            default:  branch_target = pc + imm_b;
        endcase
    end

    always_comb begin
        writes_rd = 1'b1;
        case (opcode)
            OPC_OP, OPC_OP_IMM: rd_sel = RD_SEL_ALU;
            OPC_LOAD:           rd_sel = RD_SEL_LOAD;
            OPC_LUI:            rd_sel = RD_SEL_LUI;
            OPC_AUIPC:          rd_sel = RD_SEL_AUIPC;
            OPC_JAL, OPC_JALR:  rd_sel = RD_SEL_PC_PLUS_4;
            default: begin
                rd_sel = RD_SEL_ALU;
                writes_rd = 1'b0;
            end
        endcase
    end

    // A faulting load leaves rd untouched
    assign rd_write = ready && writes_rd && !illegal && !(is_load && resp_error) &&
                      (rd_addr != 5'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= EXEC_IDLE;
            wait_cnt <= '0;
            wait_done <= 1'b0;
        end else begin
            state <= state_next;
            if (!wait_done) begin
                if (wait_cnt == CNT_W'(RESET_WAIT)) begin
                    wait_done <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/rvx_result.sv */
module rvx_result import rvx_pkg::*; (
    input  rd_sel_t    rd_sel,
    input  funct3_t    funct3,
    input  logic [1:0] byte_offset,
    input  word_t      alu_result,
    input  word_t      c_load_data,
    input  word_t      imm_u,
    input  addr_t      pc,
    output word_t      rd_wdata
);

    word_t load_shifted;
    word_t load_value;

    // Bring the addressed byte or halfword down to lane 0
    assign load_shifted = c_load_data >> {byte_offset, 3'b000};

    always_comb begin
        case (funct3)
            3'b000: load_value = {{24{load_shifted[7]}}, load_shifted[7:0]};
            3'b001: load_value = {{16{load_shifted[15]}}, load_shifted[15:0]};
            3'b100: load_value = {24'b0, load_shifted[7:0]};
            3'b101: load_value = {16'b0, load_shifted[15:0]};
            // LW and anything decode already rejected
            default: load_value = load_shifted;
        endcase
    end

    always_comb begin
        case (rd_sel)
            RD_SEL_LOAD:      rd_wdata = load_value;
            RD_SEL_LUI:       rd_wdata = imm_u;
            RD_SEL_AUIPC:     rd_wdata = pc + imm_u;
            RD_SEL_PC_PLUS_4: rd_wdata = pc + 32'd4;
            default:          rd_wdata = alu_result;
        endcase
    end

endmodule

/* rtl/rvx_execute.sv */
module rvx_execute import rvx_pkg::*; #(
    parameter int unsigned RESET_WAIT = rvx_pkg::RESET_WAIT
) (
    input  logic        clk,
    input  logic        rst_n,

    // Fetch
    input  word_t       instr,
    input  addr_t       pc,
    output logic        ready,
    output logic        branch_taken,
    output addr_t       branch_target,
    output logic        flush,
    output logic        exc_start,
    output exc_cause_t  exc_cause,
    output addr_t       exc_epc,

    // Register file
    output reg_idx_t    rs1_addr,
    input  word_t       rs1_data,
    output reg_idx_t    rs2_addr,
    input  word_t       rs2_data,
    output reg_idx_t    rd_addr,
    output word_t       rd_wdata,
    output logic        rd_write,

    // Data cache
    output cache_cmd_t  c_cmd,
    output addr_t       c_address,
    output word_t       c_store_data,
    output logic [3:0]  c_store_strb,
    input  cache_resp_t c_response,
    input  word_t       c_load_data,
    input  logic        c_reset_done
);

    opcode_t opcode;
    funct3_t funct3;
    logic    funct7_alt;
    logic    illegal;
    word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
    word_t   alu_op_b;
    word_t   alu_result;
    logic    branch_taken_alu;
    rd_sel_t rd_sel;

    assign alu_op_b = (opcode == OPC_OP_IMM) ? imm_i : rs2_data;
    assign exc_epc  = pc;

    rvx_decode i_decode (
        .instr(instr), .opcode(opcode), .funct3(funct3), .funct7_alt(funct7_alt),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
        .imm_i(imm_i), .imm_s(imm_s), .imm_b(imm_b), .imm_u(imm_u), .imm_j(imm_j),
        .illegal(illegal)
    );

    rvx_alu i_alu (
        .opcode(opcode), .funct3(funct3), .funct7_alt(funct7_alt),
        .op_a(rs1_data), .op_b(alu_op_b),
        .result(alu_result), .branch_taken(branch_taken_alu)
    );

    rvx_execute_ctrl #(.RESET_WAIT(RESET_WAIT)) i_ctrl (
        .clk(clk), .rst_n(rst_n),
        .opcode(opcode), .funct3(funct3), .rd_addr(rd_addr), .illegal(illegal),
        .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .imm_i(imm_i), .imm_s(imm_s), .imm_b(imm_b), .imm_j(imm_j),
        .branch_taken_alu(branch_taken_alu),
        .c_response(c_response), .c_reset_done(c_reset_done),
        .c_cmd(c_cmd), .c_address(c_address),
        .c_store_data(c_store_data), .c_store_strb(c_store_strb),
        .ready(ready), .flush(flush),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .exc_start(exc_start), .exc_cause(exc_cause),
        .rd_sel(rd_sel), .rd_write(rd_write)
    );

    rvx_result i_result (
        .rd_sel(rd_sel), .funct3(funct3), .byte_offset(c_address[1:0]),
        .alu_result(alu_result), .c_load_data(c_load_data),
        .imm_u(imm_u), .pc(pc), .rd_wdata(rd_wdata)
    );

endmodule

/* testbench/rvx_execute_chk.sv */
module rvx_execute_chk import rvx_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input cache_cmd_t  c_cmd,
    input cache_resp_t c_response,
    input logic        ready,
    input logic        exc_start,
    input logic        rd_write,
    input exec_state_t state
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count;

    // A command lasts exactly one cycle
    a_cmd_single: assert property (@(posedge clk) disable iff (!rst_n)
        (c_cmd != CACHE_CMD_NONE) |=> (c_cmd == CACHE_CMD_NONE))
        else begin
            $error("cache command held for more than one cycle");
            fail_count++;
        end

    a_exc_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        exc_start |-> !rd_write)
        else begin
            $error("rd written during an exception");
            fail_count++;
        end

    // No completion before the cache answers
    a_wait_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
        (state == EXEC_WAIT_RESP && c_response == CACHE_RESP_NONE) |-> !ready)
        else begin
            $error("ready high while waiting for the cache");
            fail_count++;
        end

endmodule

bind rvx_execute rvx_execute_chk i_chk (
    .clk(clk), .rst_n(rst_n), .c_cmd(c_cmd), .c_response(c_response),
    .ready(ready), .exc_start(exc_start), .rd_write(rd_write), .state(i_ctrl.state)
);

/* testbench/rvx_execute_tb.sv */
module rvx_execute_tb import rvx_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NF        = 17;
    localparam int MAX_TESTS = 64;
    localparam int MEM_SIZE  = MAX_TESTS * NF;

    logic        clk;
    logic        rst_n;
    word_t       instr;
    addr_t       pc;
    logic        ready;
    logic        branch_taken;
    addr_t       branch_target;
    logic        flush;
    logic        exc_start;
    exc_cause_t  exc_cause;
    addr_t       exc_epc;
    reg_idx_t    rs1_addr;
    word_t       rs1_data;
    reg_idx_t    rs2_addr;
    word_t       rs2_data;
    reg_idx_t    rd_addr;
    word_t       rd_wdata;
    logic        rd_write;
    cache_cmd_t  c_cmd;
    addr_t       c_address;
    word_t       c_store_data;
    logic [3:0]  c_store_strb;
    cache_resp_t c_response;
    word_t       c_load_data;
    logic        c_reset_done;

    word_t       vec [0:MEM_SIZE-1];
    int          num_tests;
    int          max_lat;
    longint      limit_ns;
    int          cur_test;
    int          check_errors;
    int          tests_passed;
    int          tests_failed;

    // Shared with the cache model
    int          cur_lat;
    cache_resp_t cur_resp;
    word_t       cur_load;
    cache_cmd_t  seen_cmd;
    addr_t       seen_addr;
    word_t       seen_data;
    logic [3:0]  seen_strb;

    rvx_execute #(.RESET_WAIT(RESET_WAIT)) i_dut (.*);

    always #10 clk = ~clk;

    // Unused slots hold a value tied to their index so the end of the list shows
    function automatic word_t fill_value(input int idx);
        return 32'hEEEE_0000 ^ word_t'(idx);
    endfunction

    function automatic word_t field(input int t, input int i);
        return vec[t * NF + i];
    endfunction

    task automatic word_check(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED test %0d %s: got %08h, expected %08h", cur_test, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic addr_check(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("FAILED test %0d %s: got %08h, expected %08h", cur_test, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic reg_check(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("FAILED test %0d %s: got %02h, expected %02h", cur_test, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic cause_check(input string name, input exc_cause_t got, input exc_cause_t exp);
        if (got !== exp) begin
            $display("FAILED test %0d %s: got %h, expected %h", cur_test, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic cmd_check(input string name, input cache_cmd_t got, input cache_cmd_t exp);
        if (got !== exp) begin
            $display("FAILED test %0d %s: got %h, expected %h", cur_test, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic strb_check(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("FAILED test %0d %s: got %h, expected %h", cur_test, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic bit_check(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED test %0d %s: got %h, expected %h", cur_test, name, got, exp);
            check_errors++;
        end
    endtask

    task automatic run_test(input int t);
        int    errors_before;
        int    cycles;
        int    exp_cycles;
        word_t exp_cmd;
        word_t exp_instr;
        logic  exp_exc;
        begin
            errors_before = check_errors;
            cur_test = t;
            cur_lat  = int'(field(t, 4));
            cur_resp = cache_resp_t'(field(t, 5) & 32'h3);
            cur_load = field(t, 6);
            seen_cmd  = CACHE_CMD_NONE;
            seen_addr = '0;
            seen_data = '0;
            seen_strb = '0;
            exp_instr = field(t, 0);
            exp_cmd = field(t, 13);
            exp_exc = field(t, 11) != 0;
            instr    <= exp_instr;
            pc       <= field(t, 1);
            rs1_data <= field(t, 2);
            rs2_data <= field(t, 3);
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
            end while (ready !== 1'b1);

            // Register file addresses come straight from the RV32I fields
            reg_check("rs1_addr", rs1_addr, exp_instr[19:15]);
            reg_check("rs2_addr", rs2_addr, exp_instr[24:20]);
            bit_check("rd_write", rd_write, field(t, 7) != 0);
            if (field(t, 7) != 0) begin
                reg_check("rd_addr", rd_addr, exp_instr[11:7]);
                word_check("rd_wdata", rd_wdata, field(t, 8));
            end
            bit_check("branch_taken", branch_taken, field(t, 9) != 0);
            if (field(t, 9) != 0) begin
                addr_check("branch_target", branch_target, field(t, 10));
            end
            bit_check("exc_start", exc_start, exp_exc);
            if (exp_exc) begin
                cause_check("exc_cause", exc_cause, exc_cause_t'(field(t, 12) & 32'hF));
                addr_check("exc_epc", exc_epc, field(t, 1));
            end
            bit_check("flush", flush, (exp_cmd == 3) && !exp_exc);
            cmd_check("c_cmd", seen_cmd, cache_cmd_t'(exp_cmd & 32'h3));
            if (exp_cmd == 1 || exp_cmd == 2) begin
                addr_check("c_address", seen_addr, field(t, 14));
            end
            if (exp_cmd == 2) begin
                word_check("c_store_data", seen_data, field(t, 15));
                strb_check("c_store_strb", seen_strb, 4'(field(t, 16)));
            end

            // Memory work takes the command cycle plus the cache latency
            exp_cycles = (exp_cmd == 0) ? 1 : cur_lat + 1;
            if (cycles != exp_cycles) begin
                $display("Test %0d took %0d cycles to complete instead of %0d",
                         t, cycles, exp_cycles);
                check_errors++;
            end

            if (check_errors == errors_before) begin
                $display("test %0d instr %08h ok", t, exp_instr);
                tests_passed++;
            end else begin
                $display("test %0d instr %08h had errors", t, exp_instr);
                tests_failed++;
            end
        end
    endtask

    // Cache model answering each command after the latency of the current test
    initial begin
        forever begin
            @(posedge clk);
            if (c_cmd != CACHE_CMD_NONE) begin
                seen_cmd  = c_cmd;
                seen_addr = c_address;
                seen_data = c_store_data;
                seen_strb = c_store_strb;
                repeat (cur_lat - 1) @(posedge clk);
                c_response  <= cur_resp;
                c_load_data <= cur_load;
                @(posedge clk);
                c_response <= CACHE_RESP_NONE;
            end
        end
    end

    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("Watchdog expired after %0d ns, the tests did not complete", limit_ns);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        instr        = 32'h0000_0013;
        pc           = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        c_response   = CACHE_RESP_NONE;
        c_load_data  = '0;
        c_reset_done = 1'b0;
        check_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        cur_lat      = 1;

        for (int i = 0; i < MEM_SIZE; i++) begin
            vec[i] = fill_value(i);
        end
        $readmemh("testbench/rvx_execute_tests.txt", vec);
        num_tests = 0;
        max_lat   = 0;
        while (num_tests < MAX_TESTS && vec[num_tests * NF] !== fill_value(num_tests * NF)) begin
            if (int'(field(num_tests, 4)) > max_lat) begin
                max_lat = int'(field(num_tests, 4));
            end
            num_tests++;
        end
        limit_ns = longint'(num_tests) * (max_lat + 4) * 20 + (16 + RESET_WAIT + 4) * 20;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        c_reset_done <= 1'b1;
        repeat (RESET_WAIT + 4) @(posedge clk);

        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end

        $display("tests %0d, passed %0d, failed %0d, check errors %0d, assertion errors %0d",
                 num_tests, tests_passed, tests_failed, check_errors,
                 i_dut.i_chk.fail_count);
        if (num_tests > 0 && tests_failed == 0 && check_errors == 0 &&
                i_dut.i_chk.fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* testbench/rvx_execute_tests.txt */
// instr pc rs1 rs2 latency resp(1 done 2 error) load_word exp_rd_write exp_rd_wdata
// exp_branch exp_target exp_exc exp_cause exp_cmd exp_c_address exp_store_data exp_strb
00510093 100 10 0 0 0 0 1 15 0 0 0 0 0 0 0 0
002081B3 100 7 9 0 0 0 1 10 0 0 0 0 0 0 0 0
402081B3 100 5 7 0 0 0 1 FFFFFFFE 0 0 0 0 0 0 0 0
002091B3 100 1 24 0 0 0 1 10 0 0 0 0 0 0 0 0
0020A1B3 100 FFFFFFFF 1 0 0 0 1 1 0 0 0 0 0 0 0 0
0020B1B3 100 FFFFFFFF 1 0 0 0 1 0 0 0 0 0 0 0 0 0
0020C1B3 100 F0F0 FF0 0 0 0 1 FF00 0 0 0 0 0 0 0 0
0020D1B3 100 80000000 4 0 0 0 1 8000000 0 0 0 0 0 0 0 0
4020D1B3 100 80000000 4 0 0 0 1 F8000000 0 0 0 0 0 0 0 0
0020E1B3 100 F00 F0 0 0 0 1 FF0 0 0 0 0 0 0 0 0
0020F1B3 100 FF00 FF0 0 0 0 1 F00 0 0 0 0 0 0 0 0
40415093 100 80000000 0 0 0 0 1 F8000000 0 0 0 0 0 0 0 0
FFF10093 100 10 0 0 0 0 1 F 0 0 0 0 0 0 0 0
123452B7 100 0 0 0 0 0 1 12345000 0 0 0 0 0 0 0 0
00001297 100 0 0 0 0 0 1 1100 0 0 0 0 0 0 0 0
00510013 100 10 0 0 0 0 0 0 0 0 0 0 0 0 0 0
00208863 100 5 5 0 0 0 0 0 1 110 0 0 0 0 0 0
00209863 100 5 5 0 0 0 0 0 0 0 0 0 0 0 0 0
FE20CCE3 100 FFFFFFFF 1 0 0 0 0 0 1 F8 0 0 0 0 0 0
0020F863 100 FFFFFFFF 1 0 0 0 0 0 1 110 0 0 0 0 0 0
020000EF 100 0 0 0 0 0 1 104 1 120 0 0 0 0 0 0
003100E7 100 200 0 0 0 0 1 104 1 202 0 0 0 0 0 0
00110083 100 1000 0 1 1 11228044 1 FFFFFF80 0 0 0 0 1 1001 0 0
00114083 100 1000 0 2 1 11228044 1 80 0 0 0 0 1 1001 0 0
00211083 100 1000 0 4 1 9A5B0000 1 FFFF9A5B 0 0 0 0 1 1002 0 0
00215083 100 1000 0 5 1 9A5B0000 1 9A5B 0 0 0 0 1 1002 0 0
00012083 100 1000 0 1 1 DEADBEEF 1 DEADBEEF 0 0 0 0 1 1000 0 0
00310083 100 1000 0 3 1 7F000000 1 7F 0 0 0 0 1 1003 0 0
00012083 100 1000 0 2 2 DEADBEEF 0 0 0 0 1 5 1 1000 0 0
003100A3 100 2000 123456AB 1 1 0 0 0 0 0 0 0 2 2001 3456AB00 2
00311123 100 2000 123456AB 2 1 0 0 0 0 0 0 0 2 2002 56AB0000 C
00312223 100 2000 123456AB 5 1 0 0 0 0 0 0 0 2 2004 123456AB F
00312223 100 2000 123456AB 3 2 0 0 0 0 0 1 7 2 2004 123456AB F
00000073 200 0 0 0 0 0 0 0 0 0 1 2 0 0 0 0
0000007F 200 0 0 0 0 0 0 0 0 0 1 2 0 0 0 0
022081B3 200 1 2 0 0 0 0 0 0 0 1 2 0 0 0 0
00013083 200 1000 0 0 0 0 0 0 0 0 1 2 0 0 0 0
003110E7 200 200 0 0 0 0 0 0 0 0 1 2 0 0 0 0
0FF0000F 300 0 0 2 1 0 0 0 0 0 0 0 3 0 0 0
8330000F 300 0 0 0 0 0 0 0 0 0 1 2 0 0 0 0

/* flist.f */
rtl/rvx_pkg.sv
rtl/rvx_decode.sv
rtl/rvx_alu.sv
rtl/rvx_execute_ctrl.sv
rtl/rvx_result.sv
rtl/rvx_execute.sv
testbench/rvx_execute_chk.sv
testbench/rvx_execute_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module rvx_execute_tb \
    -f flist.f \
    -o rvx_execute_sim

./obj_dir/rvx_execute_sim > sim.log 2>&1
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0
